// File: hw/decode_cfg.svh
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Bus widths
`define DATA_W 8
`define ADDR_W 16
`define FLAG_W 8

// Status register bit positions
`define CARRY_BIT    0
`define ZERO_BIT     1
`define OVERFLOW_BIT 6
`define NEGATIVE_BIT 7

`endif

// File: hw/decode_pkg.sv
`include "decode_cfg.svh"

package decode_pkg;

    typedef enum logic [`DATA_W-1:0] {
        OP_NOP     = 8'hEA,
        OP_SEC     = 8'h38, OP_CLC = 8'h18, OP_CLV = 8'hB8,
        OP_TAX     = 8'hAA, OP_TAY = 8'hA8, OP_TXA = 8'h8A, OP_TYA = 8'h98,
        OP_INX     = 8'hE8, OP_INY = 8'hC8, OP_DEX = 8'hCA, OP_DEY = 8'h88,
        OP_ASL_A   = 8'h0A, OP_LSR_A = 8'h4A,
        OP_LDA_IMM = 8'hA9, OP_LDA_ZP = 8'hA5, OP_LDA_ABS = 8'hAD,
        OP_LDX_IMM = 8'hA2, OP_LDX_ZP = 8'hA6, OP_LDX_ABS = 8'hAE,
        OP_LDY_IMM = 8'hA0, OP_LDY_ZP = 8'hA4, OP_LDY_ABS = 8'hAC,
        OP_AND_IMM = 8'h29, OP_AND_ZP = 8'h25, OP_AND_ABS = 8'h2D,
        OP_ORA_IMM = 8'h09, OP_ORA_ZP = 8'h05, OP_ORA_ABS = 8'h0D,
        OP_EOR_IMM = 8'h49, OP_EOR_ZP = 8'h45, OP_EOR_ABS = 8'h4D,
        OP_ADC_IMM = 8'h69, OP_ADC_ZP = 8'h65, OP_ADC_ABS = 8'h6D,
        OP_SBC_IMM = 8'hE9, OP_SBC_ZP = 8'hE5, OP_SBC_ABS = 8'hED,
        OP_STA_ZP  = 8'h85, OP_STA_ABS = 8'h8D,
        OP_STX_ZP  = 8'h86, OP_STX_ABS = 8'h8E,
        OP_STY_ZP  = 8'h84, OP_STY_ABS = 8'h8C,
        OP_JMP_ABS = 8'h4C,
        OP_BCS     = 8'hB0
    } opcode_t;

    typedef enum logic [3:0] {
        ST_IDLE, ST_FETCH, ST_ADDR_LO, ST_ADDR_HI, ST_OPERAND,
        ST_EXECUTE, ST_WRITEBACK, ST_MEM_WRITE, ST_PC_LOAD, ST_BRANCH
    } state_t;

    typedef enum logic [3:0] {
        CLS_NOP, CLS_FLAG, CLS_TRANSFER, CLS_REG_ALU, CLS_LOAD,
        CLS_ALU, CLS_STORE, CLS_JUMP, CLS_BRANCH, CLS_ILLEGAL
    } op_class_t;

    typedef enum logic [2:0] {
        AM_IMPLIED, AM_IMMEDIATE, AM_ZERO_PAGE, AM_ABSOLUTE, AM_RELATIVE
    } addr_mode_t;

    typedef enum logic [1:0] {SEL_NONE, SEL_A, SEL_X, SEL_Y} reg_sel_t;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ASL, ALU_LSR, ALU_AND, ALU_OR, ALU_XOR,
        ALU_ADD, ALU_SUB, ALU_INC, ALU_DEC, ALU_FLG, ALU_TMX
    } alu_op_t;

    typedef enum logic [1:0] {
        BUF_IDLE  = 2'b00,
        BUF_LOAD  = 2'b01,
        BUF_STORE = 2'b10
    } buf_op_t;

    // Bit 2 enable, bit 1 drives the bus, bit 0 picks bus 2
    typedef enum logic [2:0] {
        REG_IDLE       = 3'b000,
        REG_LOAD_BUS1  = 3'b100,
        REG_LOAD_BUS2  = 3'b101,
        REG_STORE_BUS1 = 3'b110,
        REG_STORE_BUS2 = 3'b111
    } reg_op_t;

    typedef enum logic [1:0] {PC_HOLD, PC_INC, PC_LOAD, PC_BRANCH} pc_op_t;

    typedef enum logic {ASEL_PC, ASEL_OPERAND} addr_sel_t;

endpackage

// File: hw/opcode_classifier.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module opcode_classifier import decode_pkg::*; (
    input  logic [`DATA_W-1:0] instruction,
    output op_class_t          op_class,
    output addr_mode_t         addr_mode,
    output reg_sel_t           target,
    output alu_op_t            alu_op
);

    opcode_t op;

    assign op = opcode_t'(instruction);

    always_comb begin
        case (op)
            OP_NOP: op_class = CLS_NOP;
            OP_SEC, OP_CLC, OP_CLV: op_class = CLS_FLAG;
            OP_TAX, OP_TAY, OP_TXA, OP_TYA: op_class = CLS_TRANSFER;
            OP_INX, OP_INY, OP_DEX, OP_DEY, OP_ASL_A, OP_LSR_A: op_class = CLS_REG_ALU;
            OP_LDA_IMM, OP_LDA_ZP, OP_LDA_ABS, OP_LDX_IMM, OP_LDX_ZP, OP_LDX_ABS,
            OP_LDY_IMM, OP_LDY_ZP, OP_LDY_ABS: op_class = CLS_LOAD;
            OP_AND_IMM, OP_AND_ZP, OP_AND_ABS, OP_ORA_IMM, OP_ORA_ZP, OP_ORA_ABS,
            OP_EOR_IMM, OP_EOR_ZP, OP_EOR_ABS, OP_ADC_IMM, OP_ADC_ZP, OP_ADC_ABS,
            OP_SBC_IMM, OP_SBC_ZP, OP_SBC_ABS: op_class = CLS_ALU;
            OP_STA_ZP, OP_STA_ABS, OP_STX_ZP, OP_STX_ABS,
            OP_STY_ZP, OP_STY_ABS: op_class = CLS_STORE;
            OP_JMP_ABS: op_class = CLS_JUMP;
            OP_BCS: op_class = CLS_BRANCH;
            default: op_class = CLS_ILLEGAL;
        endcase
    end

    always_comb begin
        case (op)
            OP_LDA_IMM, OP_LDX_IMM, OP_LDY_IMM, OP_AND_IMM, OP_ORA_IMM,
            OP_EOR_IMM, OP_ADC_IMM, OP_SBC_IMM: addr_mode = AM_IMMEDIATE;
            OP_LDA_ZP, OP_LDX_ZP, OP_LDY_ZP, OP_AND_ZP, OP_ORA_ZP, OP_EOR_ZP,
            OP_ADC_ZP, OP_SBC_ZP, OP_STA_ZP, OP_STX_ZP, OP_STY_ZP: addr_mode = AM_ZERO_PAGE;
            OP_LDA_ABS, OP_LDX_ABS, OP_LDY_ABS, OP_AND_ABS, OP_ORA_ABS, OP_EOR_ABS,
            OP_ADC_ABS, OP_SBC_ABS, OP_STA_ABS, OP_STX_ABS, OP_STY_ABS,
            OP_JMP_ABS: addr_mode = AM_ABSOLUTE;
            OP_BCS: addr_mode = AM_RELATIVE;
            default: addr_mode = AM_IMPLIED;
        endcase
    end

    always_comb begin
        case (op)
            OP_LDA_IMM, OP_LDA_ZP, OP_LDA_ABS, OP_STA_ZP, OP_STA_ABS, OP_ASL_A, OP_LSR_A,
            OP_AND_IMM, OP_AND_ZP, OP_AND_ABS, OP_ORA_IMM, OP_ORA_ZP, OP_ORA_ABS,
            OP_EOR_IMM, OP_EOR_ZP, OP_EOR_ABS, OP_ADC_IMM, OP_ADC_ZP, OP_ADC_ABS,
            OP_SBC_IMM, OP_SBC_ZP, OP_SBC_ABS: target = SEL_A;
            OP_LDX_IMM, OP_LDX_ZP, OP_LDX_ABS, OP_STX_ZP, OP_STX_ABS,
            OP_TAX, OP_TXA, OP_INX, OP_DEX: target = SEL_X;  // Transfers name the index side
            OP_LDY_IMM, OP_LDY_ZP, OP_LDY_ABS, OP_STY_ZP, OP_STY_ABS,
            OP_TAY, OP_TYA, OP_INY, OP_DEY: target = SEL_Y;
            default: target = SEL_NONE;
        endcase
    end

    // For flag ops INC sets carry, DEC clears it and FLG clears overflow
    always_comb begin
        case (op)
            OP_SEC, OP_INX, OP_INY: alu_op = ALU_INC;
            OP_CLC, OP_DEX, OP_DEY: alu_op = ALU_DEC;
            OP_CLV, OP_LDA_IMM, OP_LDA_ZP, OP_LDA_ABS, OP_LDX_IMM, OP_LDX_ZP, OP_LDX_ABS,
            OP_LDY_IMM, OP_LDY_ZP, OP_LDY_ABS: alu_op = ALU_FLG;
            OP_TAX, OP_TAY: alu_op = ALU_TMX;  // Accumulator is the source
            OP_ASL_A: alu_op = ALU_ASL;
            OP_LSR_A: alu_op = ALU_LSR;
            OP_AND_IMM, OP_AND_ZP, OP_AND_ABS: alu_op = ALU_AND;
            OP_ORA_IMM, OP_ORA_ZP, OP_ORA_ABS: alu_op = ALU_OR;
            OP_EOR_IMM, OP_EOR_ZP, OP_EOR_ABS: alu_op = ALU_XOR;
            OP_ADC_IMM, OP_ADC_ZP, OP_ADC_ABS: alu_op = ALU_ADD;
            OP_SBC_IMM, OP_SBC_ZP, OP_SBC_ABS: alu_op = ALU_SUB;
            default: alu_op = ALU_NOP;
        endcase
    end

endmodule

// File: hw/operand_latch.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module operand_latch import decode_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clk_enable,
    input  logic [`DATA_W-1:0] instruction,
    input  state_t             next_state,
    input  op_class_t          op_class,
    input  addr_mode_t         addr_mode,
    input  reg_sel_t           target,
    input  alu_op_t            alu_op,
    output op_class_t          cur_class,
    output addr_mode_t         cur_mode,
    output reg_sel_t           cur_target,
    output alu_op_t            cur_alu,
    output logic               cur_is_bcs,
    output logic [`ADDR_W-1:0] operand_address
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_class       <= CLS_NOP;
            cur_mode        <= AM_IMPLIED;
            cur_target      <= SEL_NONE;
            cur_alu         <= ALU_NOP;
            cur_is_bcs      <= 1'b0;
            operand_address <= '0;
        end else if (clk_enable) begin
            case (next_state)
                ST_FETCH: begin  // Opcode byte is on the bus
                    cur_class  <= op_class;
                    cur_mode   <= addr_mode;
                    cur_target <= target;
                    cur_alu    <= alu_op;
                    cur_is_bcs <= (instruction == OP_BCS);
                end
                ST_ADDR_LO: operand_address <= {{(`ADDR_W - `DATA_W){1'b0}}, instruction};
                ST_ADDR_HI, ST_PC_LOAD: begin
                    operand_address <= {instruction, operand_address[`DATA_W-1:0]};
                end
                default: ;
            endcase
        end
    end

endmodule

// File: hw/sequencer.sv
`timescale 1ns/1ps

module sequencer import decode_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clk_enable,
    input  op_class_t  op_class,
    input  addr_mode_t addr_mode,
    input  op_class_t  cur_class,
    input  addr_mode_t cur_mode,
    output state_t     state,
    output state_t     next_state
);

    op_class_t  dec_class;
    addr_mode_t dec_mode;

    // Opcode is still on the bus in IDLE, afterwards only the latched copy is valid
    assign dec_class = (state == ST_IDLE) ? op_class : cur_class;
    assign dec_mode  = (state == ST_IDLE) ? addr_mode : cur_mode;

    always_comb begin
        next_state = ST_IDLE;
        case (state)
            ST_IDLE: next_state = ST_FETCH;
            ST_FETCH: begin
                case (dec_class)
                    CLS_REG_ALU: next_state = ST_EXECUTE;
                    CLS_LOAD, CLS_ALU: begin
                        next_state = (dec_mode == AM_IMMEDIATE) ? ST_OPERAND : ST_ADDR_LO;
                    end
                    CLS_STORE, CLS_JUMP: next_state = ST_ADDR_LO;
                    CLS_BRANCH: next_state = ST_OPERAND;
                    default: next_state = ST_IDLE;  // Implied ops finish here
                endcase
            end
            ST_ADDR_LO: begin
                if (dec_class == CLS_JUMP) begin
                    next_state = ST_PC_LOAD;
                end else if (dec_mode == AM_ABSOLUTE) begin
                    next_state = ST_ADDR_HI;
                end else if (dec_class == CLS_STORE) begin
                    next_state = ST_WRITEBACK;
                end else begin
                    next_state = ST_OPERAND;
                end
            end
            ST_ADDR_HI: next_state = (dec_class == CLS_STORE) ? ST_WRITEBACK : ST_OPERAND;
            ST_OPERAND: next_state = (dec_class == CLS_BRANCH) ? ST_BRANCH : ST_EXECUTE;
            ST_EXECUTE: next_state = ST_WRITEBACK;
            ST_WRITEBACK: next_state = (dec_class == CLS_STORE) ? ST_MEM_WRITE : ST_IDLE;
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else if (clk_enable) begin
            state <= next_state;
        end
    end

endmodule

// File: hw/control_decode.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module control_decode import decode_pkg::*; (
    input  state_t             state,
    input  op_class_t          cur_class,
    input  addr_mode_t         cur_mode,
    input  reg_sel_t           cur_target,
    input  alu_op_t            cur_alu,
    input  logic               cur_is_bcs,
    input  logic [`ADDR_W-1:0] operand_address,
    input  logic [`FLAG_W-1:0] status,
    output logic [`ADDR_W-1:0] memory_address,
    output addr_sel_t          address_select,
    output logic               rw,
    output buf_op_t            data_buffer_op,
    output buf_op_t            input_latch_op,
    output pc_op_t             pc_op,
    output alu_op_t            alu_op,
    output reg_op_t            acc_op,
    output reg_op_t            x_op,
    output reg_op_t            y_op,
    output logic [`FLAG_W-1:0] status_write,
    output logic [`FLAG_W-1:0] status_value
);

    localparam logic [`FLAG_W-1:0] C_MASK  = `FLAG_W'(1) << `CARRY_BIT;
    localparam logic [`FLAG_W-1:0] V_MASK  = `FLAG_W'(1) << `OVERFLOW_BIT;
    localparam logic [`FLAG_W-1:0] ZN_MASK = (`FLAG_W'(1) << `ZERO_BIT)
                                           | (`FLAG_W'(1) << `NEGATIVE_BIT);

    reg_op_t tgt_op;  // Operation for the register named by cur_target
    logic    is_shift;

    assign is_shift = (cur_alu == ALU_ASL) || (cur_alu == ALU_LSR);

    always_comb begin
        memory_address = '0;
        address_select = ASEL_PC;
        rw             = 1'b1;
        data_buffer_op = BUF_IDLE;
        input_latch_op = BUF_IDLE;
        pc_op          = PC_HOLD;
        alu_op         = ALU_NOP;
        acc_op         = REG_IDLE;
        x_op           = REG_IDLE;
        y_op           = REG_IDLE;
        status_write   = '0;
        status_value   = '0;
        tgt_op         = REG_IDLE;
        case (state)
            ST_FETCH: begin
                pc_op = PC_INC;
                if (cur_class == CLS_FLAG) begin
                    case (cur_alu)
                        ALU_INC: begin
                            status_write = C_MASK;
                            status_value = C_MASK;
                        end
                        ALU_DEC: status_write = C_MASK;
                        default: status_write = V_MASK;
                    endcase
                end else if (cur_class == CLS_TRANSFER) begin
                    if (cur_alu == ALU_TMX) begin  // A into X or Y
                        acc_op = REG_STORE_BUS1;
                        tgt_op = REG_LOAD_BUS1;
                    end else begin
                        acc_op = REG_LOAD_BUS1;
                        tgt_op = REG_STORE_BUS1;
                    end
                end
            end
            ST_ADDR_LO: pc_op = PC_INC;
            ST_ADDR_HI: begin
                pc_op          = PC_INC;
                address_select = ASEL_OPERAND;
                memory_address = operand_address;
            end
            ST_OPERAND: begin
                input_latch_op = BUF_LOAD;
                if (cur_mode == AM_IMMEDIATE) begin
                    pc_op = PC_INC;  // Skip past the immediate byte
                end
                if (cur_mode == AM_ZERO_PAGE) begin
                    address_select = ASEL_OPERAND;
                    memory_address = operand_address;
                end
            end
            ST_EXECUTE: begin
                status_write = ZN_MASK;
                case (cur_class)
                    CLS_LOAD: begin
                        input_latch_op = BUF_STORE;
                        alu_op         = ALU_FLG;
                    end
                    CLS_ALU: begin
                        input_latch_op = BUF_STORE;
                        acc_op         = REG_STORE_BUS2;
                        alu_op         = cur_alu;
                    end
                    CLS_REG_ALU: begin
                        tgt_op       = REG_STORE_BUS1;
                        alu_op       = cur_alu;
                        status_write = is_shift ? (ZN_MASK | C_MASK) : ZN_MASK;
                    end
                    default: status_write = '0;
                endcase
            end
            ST_WRITEBACK: begin
                if (cur_class == CLS_STORE) begin
                    tgt_op         = REG_STORE_BUS2;
                    data_buffer_op = BUF_LOAD;
                end else begin
                    alu_op = ALU_TMX;
                    tgt_op = REG_LOAD_BUS2;
                end
            end
            ST_MEM_WRITE: begin
                data_buffer_op = BUF_STORE;
                rw             = 1'b0;
                address_select = ASEL_OPERAND;
                memory_address = operand_address;
            end
            ST_PC_LOAD: begin
                pc_op          = PC_LOAD;
                memory_address = operand_address;
            end
            ST_BRANCH: begin
                if (cur_is_bcs && status[`CARRY_BIT]) begin
                    input_latch_op = BUF_STORE;  // Offset goes to the PC adder
                    pc_op          = PC_BRANCH;
                end
            end
            default: ;
        endcase

        if (tgt_op != REG_IDLE) begin
            case (cur_target)
                SEL_A: acc_op = tgt_op;
                SEL_X: x_op = tgt_op;
                SEL_Y: y_op = tgt_op;
                default: ;
            endcase
        end
    end

endmodule

// File: hw/decode_top.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module decode_top import decode_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clk_enable,
    input  logic [`DATA_W-1:0] instruction,
    input  logic [`FLAG_W-1:0] status,
    output logic [`ADDR_W-1:0] memory_address,
    output addr_sel_t          address_select,
    output logic               rw,
    output buf_op_t            data_buffer_op,
    output buf_op_t            input_latch_op,
    output pc_op_t             pc_op,
    output alu_op_t            alu_op,
    output reg_op_t            acc_op,
    output reg_op_t            x_op,
    output reg_op_t            y_op,
    output logic [`FLAG_W-1:0] status_write,
    output logic [`FLAG_W-1:0] status_value
);

    op_class_t          op_class;
    addr_mode_t         addr_mode;
    reg_sel_t           target;
    alu_op_t            dec_alu;  // Classifier view of the byte on the bus
    state_t             state;
    state_t             next_state;
    op_class_t          cur_class;
    addr_mode_t         cur_mode;
    reg_sel_t           cur_target;
    alu_op_t            cur_alu;
    logic               cur_is_bcs;
    logic [`ADDR_W-1:0] operand_address;

    opcode_classifier i_opcode_classifier (
        .instruction (instruction),
        .op_class    (op_class),
        .addr_mode   (addr_mode),
        .target      (target),
        .alu_op      (dec_alu)
    );

    operand_latch i_operand_latch (
        .clk             (clk),
        .rst_n           (rst_n),
        .clk_enable      (clk_enable),
        .instruction     (instruction),
        .next_state      (next_state),
        .op_class        (op_class),
        .addr_mode       (addr_mode),
        .target          (target),
        .alu_op          (dec_alu),
        .cur_class       (cur_class),
        .cur_mode        (cur_mode),
        .cur_target      (cur_target),
        .cur_alu         (cur_alu),
        .cur_is_bcs      (cur_is_bcs),
        .operand_address (operand_address)
    );

    sequencer i_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .clk_enable (clk_enable),
        .op_class   (op_class),
        .addr_mode  (addr_mode),
        .cur_class  (cur_class),
        .cur_mode   (cur_mode),
        .state      (state),
        .next_state (next_state)
    );

    control_decode i_control_decode (
        .state           (state),
        .cur_class       (cur_class),
        .cur_mode        (cur_mode),
        .cur_target      (cur_target),
        .cur_alu         (cur_alu),
        .cur_is_bcs      (cur_is_bcs),
        .operand_address (operand_address),
        .status          (status),
        .memory_address  (memory_address),
        .address_select  (address_select),
        .rw              (rw),
        .data_buffer_op  (data_buffer_op),
        .input_latch_op  (input_latch_op),
        .pc_op           (pc_op),
        .alu_op          (alu_op),
        .acc_op          (acc_op),
        .x_op            (x_op),
        .y_op            (y_op),
        .status_write    (status_write),
        .status_value    (status_value)
    );

endmodule

// File: verification/decode_vectors.svh
`ifndef DECODE_VECTORS_SVH
`define DECODE_VECTORS_SVH

// Columns are test, instruction, clk_enable and status, then the expected control word
// memory_address, address_select, rw, data_buffer_op, input_latch_op, pc_op, alu_op,
// acc_op, x_op, y_op, status_write and status_value
// address_select 0 PC and 1 operand
// Buffers 0 idle, 1 load and 2 store
// pc 0 hold, 1 inc, 2 load and 3 branch
// Registers 0 idle, 4/5 load bus1/bus2 and 6/7 store bus1/bus2
// alu 0 nop, 1 asl, 3 and, 8 inc, 10 flg and 11 tmx

typedef struct {
    int test;
    int instr;
    int en;
    int status;
    int addr;
    int asel;
    int rw;
    int dbuf;
    int ilat;
    int pc;
    int alu;
    int acc;
    int x;
    int y;
    int sw;
    int sv;
} vector_t;

localparam int NUM_ROWS = 60;

vector_t vectors [NUM_ROWS] = '{
    '{1, 'hEA, 0, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // Held in IDLE
    '{1, 'hEA, 0, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},
    '{2, 'h38, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // SEC
    '{2, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h01, 'h01},
    '{2, 'h18, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // CLC
    '{2, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h01, 'h00},
    '{2, 'hB8, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // CLV
    '{2, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h40, 'h00},
    '{2, 'hAA, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // TAX
    '{2, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 6, 4, 0, 'h00, 'h00},
    '{2, 'h98, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // TYA
    '{2, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 4, 0, 6, 'h00, 'h00},
    '{4, 'h8E, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // STX abs
    '{4, 'h12, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{4, 'h34, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{4, 'hEA, 1, 'h00, 'h3412, 1, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},  // ADDR_HI
    '{4, 'hEA, 1, 'h00, 'h0000, 0, 1, 1, 0, 0,  0, 0, 7, 0, 'h00, 'h00},
    '{4, 'hEA, 1, 'h00, 'h3412, 1, 0, 2, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // MEM_WRITE
    '{4, 'h4C, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // JMP
    '{4, 'h80, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{4, 'hC0, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{4, 'hEA, 1, 'h00, 'hC080, 0, 1, 0, 0, 2,  0, 0, 0, 0, 'h00, 'h00},  // PC_LOAD
    '{3, 'hA9, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // LDA #
    '{3, 'h5C, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{3, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 1, 1,  0, 0, 0, 0, 'h00, 'h00},  // OPERAND
    '{3, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 2, 0, 10, 0, 0, 0, 'h82, 'h00},
    '{3, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 0, 11, 5, 0, 0, 'h00, 'h00},
    '{3, 'h25, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // AND zp
    '{3, 'h3C, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{3, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},  // ADDR_LO
    '{3, 'hEA, 1, 'h00, 'h003C, 1, 1, 0, 1, 0,  0, 0, 0, 0, 'h00, 'h00},  // Upper byte cleared
    '{3, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 2, 0,  3, 7, 0, 0, 'h82, 'h00},
    '{3, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 0, 11, 5, 0, 0, 'h00, 'h00},
    '{5, 'hB0, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // BCS, carry clear
    '{5, 'h10, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{5, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 1, 0,  0, 0, 0, 0, 'h00, 'h00},
    '{5, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // Not taken
    '{5, 'hB0, 1, 'h01, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // BCS, carry set
    '{5, 'h10, 1, 'h01, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{5, 'hEA, 1, 'h01, 'h0000, 0, 1, 0, 1, 0,  0, 0, 0, 0, 'h00, 'h00},
    '{5, 'hEA, 1, 'h01, 'h0000, 0, 1, 0, 2, 3,  0, 0, 0, 0, 'h00, 'h00},  // Taken
    '{5, 'hE8, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // INX
    '{5, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{5, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  8, 0, 6, 0, 'h82, 'h00},
    '{5, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 0, 11, 0, 5, 0, 'h00, 'h00},
    '{5, 'h0A, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // ASL A
    '{5, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{5, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  1, 6, 0, 0, 'h83, 'h00},  // Carry in mask
    '{5, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 0, 11, 5, 0, 0, 'h00, 'h00},
    '{6, 'hAD, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00},  // LDA abs
    '{6, 'h45, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{6, 'hFF, 0, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},  // Stalled in ADDR_LO
    '{6, 'hFF, 0, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{6, 'hFF, 0, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{6, 'h21, 1, 'h00, 'h0000, 0, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{6, 'hEA, 1, 'h00, 'h2145, 1, 1, 0, 0, 1,  0, 0, 0, 0, 'h00, 'h00},
    '{6, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 1, 0,  0, 0, 0, 0, 'h00, 'h00},
    '{6, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 2, 0, 10, 0, 0, 0, 'h82, 'h00},
    '{6, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 0, 11, 5, 0, 0, 'h00, 'h00},
    '{6, 'hEA, 1, 'h00, 'h0000, 0, 1, 0, 0, 0,  0, 0, 0, 0, 'h00, 'h00}   // Back in IDLE
};

`endif

// File: verification/tb_decode_top.sv
`timescale 1ns/1ps
`include "decode_cfg.svh"

module tb_decode_top import decode_pkg::*; ();

    localparam int RESET_CYCLES = 10;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               clk_enable;
    logic [`DATA_W-1:0] instruction;
    logic [`FLAG_W-1:0] status;
    logic [`ADDR_W-1:0] memory_address;
    addr_sel_t          address_select;
    logic               rw;
    buf_op_t            data_buffer_op;
    buf_op_t            input_latch_op;
    pc_op_t             pc_op;
    alu_op_t            alu_op;
    reg_op_t            acc_op;
    reg_op_t            x_op;
    reg_op_t            y_op;
    logic [`FLAG_W-1:0] status_write;
    logic [`FLAG_W-1:0] status_value;

    int test_errors  = 0;  // Errors in the test that is running
    int tests_passed = 0;
    int tests_failed = 0;
    int cycle_count  = 0;

    `include "decode_vectors.svh"

    localparam int CYCLE_LIMIT = NUM_ROWS + RESET_CYCLES + 20;

    decode_top i_decode_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .clk_enable     (clk_enable),
        .instruction    (instruction),
        .status         (status),
        .memory_address (memory_address),
        .address_select (address_select),
        .rw             (rw),
        .data_buffer_op (data_buffer_op),
        .input_latch_op (input_latch_op),
        .pc_op          (pc_op),
        .alu_op         (alu_op),
        .acc_op         (acc_op),
        .x_op           (x_op),
        .y_op           (y_op),
        .status_write   (status_write),
        .status_value   (status_value)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic expect_value(input string name, input int idx,
                                input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s at row %0d: expected 0x%0h, got 0x%0h",
                     name, idx, expected, actual);
            test_errors++;
        end
    endtask

    task automatic verify_control_word(input int idx);
        expect_value("memory_address", idx, vectors[idx].addr, 32'(memory_address));
        expect_value("address_select", idx, vectors[idx].asel, 32'(address_select));
        expect_value("rw", idx, vectors[idx].rw, 32'(rw));
        expect_value("data_buffer_op", idx, vectors[idx].dbuf, 32'(data_buffer_op));
        expect_value("input_latch_op", idx, vectors[idx].ilat, 32'(input_latch_op));
        expect_value("pc_op", idx, vectors[idx].pc, 32'(pc_op));
        expect_value("alu_op", idx, vectors[idx].alu, 32'(alu_op));
        expect_value("acc_op", idx, vectors[idx].acc, 32'(acc_op));
        expect_value("x_op", idx, vectors[idx].x, 32'(x_op));
        expect_value("y_op", idx, vectors[idx].y, 32'(y_op));
        expect_value("status_write", idx, vectors[idx].sw, 32'(status_write));
        expect_value("status_value", idx, vectors[idx].sv, 32'(status_value));
    endtask

    task automatic close_test(input int test);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d passed", test);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", test, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        int i;
        int next_test;
        rst_n       <= 1'b0;
        clk_enable  <= 1'b0;
        instruction <= 8'hEA;
        status      <= '0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            verify_control_word(0);  // First row holds the idle word
        end
        @(posedge clk);
        rst_n <= 1'b1;
        for (i = 0; i < NUM_ROWS; i++) begin
            @(posedge clk);
            instruction <= vectors[i].instr[`DATA_W-1:0];
            clk_enable  <= vectors[i].en[0];
            status      <= vectors[i].status[`FLAG_W-1:0];
            @(negedge clk);
            verify_control_word(i);
            next_test = (i + 1 < NUM_ROWS) ? vectors[i + 1].test : 0;
            if (next_test != vectors[i].test) begin
                close_test(vectors[i].test);
            end
        end
        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+hw
+incdir+verification
hw/decode_pkg.sv
hw/opcode_classifier.sv
hw/operand_latch.sv
hw/sequencer.sv
hw/control_decode.sv
hw/decode_top.sv
verification/tb_decode_top.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_decode_top
FILELIST = all.f
SOURCES  = $(wildcard hw/*.sv hw/*.svh verification/*.sv verification/*.svh)
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
